//--- verilog/afifo_params.svh
`ifndef AFIFO_PARAMS_SVH
`define AFIFO_PARAMS_SVH

// Stored word width.
`define AFIFO_DATA_WIDTH 8

// RAM address width, depth is 2**AFIFO_ADDR_WIDTH.
`define AFIFO_ADDR_WIDTH 4
`define AFIFO_DEPTH      16

// Used count at or above which afull is set.
`define AFIFO_AFULL_LEVEL 12

// Used count at or below which aempty is set.
`define AFIFO_AEMPTY_LEVEL 2

`endif

//--- verilog/afifo_pkg.sv
`include "afifo_params.svh"

package afifo_pkg;

  // One data word.
  typedef logic [`AFIFO_DATA_WIDTH-1:0] afifo_data_t;

  // One RAM address.
  typedef logic [`AFIFO_ADDR_WIDTH-1:0] afifo_addr_t;

  // Pointer with wrap bit, binary or Gray.
  typedef logic [`AFIFO_ADDR_WIDTH:0] afifo_ptr_t;

endpackage

//--- verilog/afifo_ram_if.sv
`timescale 1ns/10ps

interface afifo_ram_if import afifo_pkg::*; ();

  // Write group, wr_clk domain.
  logic        wr_en;
  afifo_addr_t wr_addr;
  afifo_data_t wr_data;

  // Read group, rd_clk domain.
  logic        rd_en;
  afifo_addr_t rd_addr;
  afifo_data_t rd_data;

  modport writer (
    output wr_en,
    output wr_addr
  );

  modport reader (
    output rd_en,
    output rd_addr
  );

  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

//--- verilog/afifo_ram.sv
`timescale 1ns/10ps

`include "afifo_params.svh"

module afifo_ram import afifo_pkg::*; (
  input  logic wr_clk,
  input  logic rd_clk,
  input  logic rd_rst_n,
  afifo_ram_if.mem ram
);

  afifo_data_t mem_q [`AFIFO_DEPTH];
  afifo_data_t rd_q;

  // Write port.
  always_ff @(posedge wr_clk) begin
    if (ram.wr_en) begin
      mem_q[ram.wr_addr] <= ram.wr_data;
    end
  end

  // Registered read port, holds between reads.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_q <= '0;
    end else if (ram.rd_en) begin
      rd_q <= mem_q[ram.rd_addr];
    end
  end

  assign ram.rd_data = rd_q;

endmodule

//--- verilog/afifo_ptr_sync.sv
`timescale 1ns/10ps

`include "afifo_params.svh"

module afifo_ptr_sync import afifo_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  afifo_ptr_t gray_in,
  output afifo_ptr_t bin_out
);

  afifo_ptr_t sync_q1;
  afifo_ptr_t sync_q2;

  // Two-flop crossing into the receiving domain.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  // Gray to binary.
  always_comb begin
    for (int i = 0; i <= `AFIFO_ADDR_WIDTH; i++) begin
      bin_out[i] = ^(sync_q2 >> i);
    end
  end

  // The remote counter only moves forward, never by more than a full FIFO.
  a_ptr_forward: assert property (@(posedge clk) disable iff (!rst_n)
    afifo_ptr_t'(bin_out - $past(bin_out)) <= `AFIFO_DEPTH)
    else $error("afifo_ptr_sync: pointer jumped from %h to %h", $past(bin_out), bin_out);

endmodule

//--- verilog/afifo_wr_ctrl.sv
`timescale 1ns/10ps

`include "afifo_params.svh"

module afifo_wr_ctrl import afifo_pkg::*; (
  input  logic       wr_clk,
  input  logic       wr_rst_n,
  input  logic       wr_en,
  input  afifo_ptr_t rd_ptr_wsync,
  afifo_ram_if.writer ram,
  output afifo_ptr_t wr_gray,
  output logic       full,
  output logic       afull
);

  afifo_ptr_t wr_ptr;
  afifo_ptr_t wr_ptr_nxt;
  afifo_ptr_t wr_gray_nxt;
  afifo_ptr_t rd_gray_wsync;
  afifo_ptr_t used_nxt;
  logic       wr_ok;
  logic       full_nxt;
  logic       afull_nxt;

  assign wr_ok = wr_en && !full; // Ignored when full.

  assign wr_ptr_nxt  = wr_ptr + afifo_ptr_t'(wr_ok);
  assign wr_gray_nxt = (wr_ptr_nxt >> 1) ^ wr_ptr_nxt;

  // Read pointer back to Gray for the full compare.
  assign rd_gray_wsync = (rd_ptr_wsync >> 1) ^ rd_ptr_wsync;

  // Full when wrapped once, top two Gray bits differ.
  assign full_nxt = (wr_gray_nxt == {~rd_gray_wsync[`AFIFO_ADDR_WIDTH -: 2],
                                     rd_gray_wsync[`AFIFO_ADDR_WIDTH-2:0]});

  assign used_nxt  = wr_ptr_nxt - rd_ptr_wsync;
  assign afull_nxt = (used_nxt >= `AFIFO_AFULL_LEVEL);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      wr_gray <= wr_gray_nxt;
      full    <= full_nxt;
      afull   <= afull_nxt;
    end
  end

  assign ram.wr_en   = wr_ok;
  assign ram.wr_addr = wr_ptr[`AFIFO_ADDR_WIDTH-1:0];

  // A RAM write only lands in a slot the read side has already freed.
  a_no_overwrite: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    ram.wr_en |-> afifo_ptr_t'(wr_ptr - rd_ptr_wsync) < `AFIFO_DEPTH)
    else $error("afifo_wr_ctrl: write with wr_ptr %h rd_ptr_wsync %h", wr_ptr, rd_ptr_wsync);

endmodule

//--- verilog/afifo_rd_ctrl.sv
`timescale 1ns/10ps

`include "afifo_params.svh"

module afifo_rd_ctrl import afifo_pkg::*; (
  input  logic       rd_clk,
  input  logic       rd_rst_n,
  input  logic       rd_en,
  input  afifo_ptr_t wr_ptr_rsync,
  afifo_ram_if.reader ram,
  output afifo_ptr_t rd_gray,
  output logic       empty,
  output logic       aempty
);

  afifo_ptr_t rd_ptr;
  afifo_ptr_t rd_ptr_nxt;
  afifo_ptr_t rd_gray_nxt;
  afifo_ptr_t level_nxt;
  logic       rd_ok;
  logic       empty_nxt;
  logic       aempty_nxt;

  assign rd_ok = rd_en && !empty; // Ignored when empty.

  assign rd_ptr_nxt  = rd_ptr + afifo_ptr_t'(rd_ok);
  assign rd_gray_nxt = (rd_ptr_nxt >> 1) ^ rd_ptr_nxt;

  // Pointers equal including the wrap bit.
  assign empty_nxt = (rd_ptr_nxt == wr_ptr_rsync);

  assign level_nxt  = wr_ptr_rsync - rd_ptr_nxt;
  assign aempty_nxt = (level_nxt <= `AFIFO_AEMPTY_LEVEL);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr  <= '0;
      rd_gray <= '0;
      empty   <= 1'b1;
      aempty  <= 1'b1;
    end else begin
      rd_ptr  <= rd_ptr_nxt;
      rd_gray <= rd_gray_nxt;
      empty   <= empty_nxt;
      aempty  <= aempty_nxt;
    end
  end

  assign ram.rd_en   = rd_ok;
  assign ram.rd_addr = rd_ptr[`AFIFO_ADDR_WIDTH-1:0];

  // The synchronized write side never runs more than a full FIFO ahead.
  a_level_bound: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    afifo_ptr_t'(wr_ptr_rsync - rd_ptr) <= `AFIFO_DEPTH)
    else $error("afifo_rd_ctrl: wr_ptr_rsync %h rd_ptr %h", wr_ptr_rsync, rd_ptr);

endmodule

//--- verilog/async_fifo.sv
`timescale 1ns/10ps

module async_fifo import afifo_pkg::*; (
  input  logic        wr_clk,
  input  logic        wr_rst_n,
  input  logic        wr_en,
  input  afifo_data_t wr_data,
  input  logic        rd_clk,
  input  logic        rd_rst_n,
  input  logic        rd_en,
  output afifo_data_t rd_data,
  output logic        full,
  output logic        afull,
  output logic        empty,
  output logic        aempty
);

  afifo_ptr_t wr_gray;
  afifo_ptr_t rd_gray;
  afifo_ptr_t wr_ptr_rsync;
  afifo_ptr_t rd_ptr_wsync;

  afifo_ram_if ram_bus ();

  assign ram_bus.wr_data = wr_data;
  assign rd_data         = ram_bus.rd_data;

  afifo_wr_ctrl wr_ctrl_inst (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_ptr_wsync (rd_ptr_wsync),
    .ram          (ram_bus.writer),
    .wr_gray      (wr_gray),
    .full         (full),
    .afull        (afull)
  );

  afifo_rd_ctrl rd_ctrl_inst (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_ptr_rsync (wr_ptr_rsync),
    .ram          (ram_bus.reader),
    .rd_gray      (rd_gray),
    .empty        (empty),
    .aempty       (aempty)
  );

  // Write pointer into the read domain.
  afifo_ptr_sync wr_sync_inst (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_gray),
    .bin_out (wr_ptr_rsync)
  );

  // Read pointer into the write domain.
  afifo_ptr_sync rd_sync_inst (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_gray),
    .bin_out (rd_ptr_wsync)
  );

  afifo_ram ram_inst (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .ram      (ram_bus.mem)
  );

endmodule

//--- bench/async_fifo_tb.sv
`timescale 1ns/10ps

`include "afifo_params.svh"

module async_fifo_tb import afifo_pkg::*; ();

  localparam int EXTRA_REQS     = 6;
  localparam int RAND_WR_CYCLES = 300;
  localparam int RAND_RD_CYCLES = 412; // About the same span as the write side.
  localparam int FLAG_CYCLES    = 2 * (`AFIFO_DEPTH + EXTRA_REQS) + 16;
  localparam int TIMEOUT_CYCLES = 8 + 4 * FLAG_CYCLES + 3 * (RAND_RD_CYCLES + 16) + 200;

  logic        wr_clk;
  logic        wr_rst_n;
  logic        wr_en;
  afifo_data_t wr_data;
  logic        rd_clk;
  logic        rd_rst_n;
  logic        rd_en;
  afifo_data_t rd_data;
  logic        full;
  logic        afull;
  logic        empty;
  logic        aempty;

  afifo_data_t model [$];
  int          model_count = 0;
  afifo_data_t exp_data = '0;
  afifo_data_t rd_data_prev = '0;
  logic        rd_took = 1'b0;
  logic        fill_phase = 1'b0;
  logic        drain_phase = 1'b0;
  logic        drained = 1'b0;
  logic [15:0] wr_lfsr = 16'd16066; // One stream per clock domain.
  logic [15:0] rd_lfsr = 16'd16066;
  int          errors = 0;
  int          errors_at_start = 0;
  int          passed = 0;
  int          failed = 0;

  async_fifo async_fifo_inst (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    rd_clk = 1'b0;
    forever #4 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #5.5 wr_clk = ~wr_clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic lfsr_step(logic rd_side);
    logic [15:0] state;
    logic        fb;
    state = rd_side ? rd_lfsr : wr_lfsr;
    fb    = state[15] ^ state[13] ^ state[12] ^ state[10];
    state = {state[14:0], fb};
    if (rd_side) begin
      rd_lfsr = state;
    end else begin
      wr_lfsr = state;
    end
    return fb;
  endfunction

  function automatic afifo_data_t rand_word();
    afifo_data_t w;
    for (int i = 0; i < `AFIFO_DATA_WIDTH; i++) begin
      w[i] = lfsr_step(1'b0);
    end
    return w;
  endfunction

  // True with a chance of quarters out of four.
  function automatic logic chance(int quarters, logic rd_side);
    logic [1:0] pick;
    pick[1] = lfsr_step(rd_side);
    pick[0] = lfsr_step(rd_side);
    return int'(pick) < quarters;
  endfunction

  // Reference queue with the accept rules of the ports.
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      model.push_back(wr_data);
      model_count = model.size();
    end
  end

  always @(posedge rd_clk) begin
    rd_data_prev <= rd_data;
    rd_took      <= 1'b0;
    if (rd_rst_n && rd_en && !empty) begin
      rd_took <= 1'b1;
      if (model.size() != 0) begin
        exp_data <= model.pop_front();
      end
      model_count = model.size();
    end
  end

  a_reset_rd: assert property (@(posedge rd_clk) $rose(rd_rst_n) |-> empty && aempty)
    else begin
      $display("FAILED empty/aempty after reset: got %h/%h expected 1/1",
               $sampled(empty), $sampled(aempty));
      errors++;
    end

  a_reset_wr: assert property (@(posedge wr_clk) $rose(wr_rst_n) |-> !full && !afull)
    else begin
      $display("FAILED full/afull after reset: got %h/%h expected 0/0",
               $sampled(full), $sampled(afull));
      errors++;
    end

  a_rd_data: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_took |-> rd_data == exp_data)
    else begin
      $display("FAILED rd_data: got %h expected %h", $sampled(rd_data), $sampled(exp_data));
      errors++;
    end

  a_full_safe: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    !full |-> model_count < `AFIFO_DEPTH)
    else begin
      $display("FAILED full: got 0 with model count %h", $sampled(model_count));
      errors++;
    end

  a_afull_safe: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    !afull |-> model_count < `AFIFO_AFULL_LEVEL)
    else begin
      $display("FAILED afull: got 0 with model count %h", $sampled(model_count));
      errors++;
    end

  a_empty_safe: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !empty |-> model_count >= 1)
    else begin
      $display("FAILED empty: got 0 with model count %h", $sampled(model_count));
      errors++;
    end

  a_aempty_safe: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !aempty |-> model_count > `AFIFO_AEMPTY_LEVEL)
    else begin
      $display("FAILED aempty: got 0 with model count %h", $sampled(model_count));
      errors++;
    end

  a_full_count: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    fill_phase && $rose(full) |-> model_count == `AFIFO_DEPTH)
    else begin
      $display("FAILED model count at full: got %h expected %h",
               $sampled(model_count), `AFIFO_DEPTH);
      errors++;
    end

  a_empty_count: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    drain_phase && $rose(empty) |-> model_count == 0)
    else begin
      $display("FAILED model count at empty: got %h expected 0", $sampled(model_count));
      errors++;
    end

  // Reads against an empty FIFO leave the output alone.
  a_hold_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_en && empty |=> $stable(rd_data))
    else begin
      $display("FAILED rd_data: got %h expected %h", $sampled(rd_data), $sampled(rd_data_prev));
      errors++;
    end

  a_drained: assert property (@(posedge rd_clk) drained |-> empty && model_count == 0)
    else begin
      $display("FAILED empty after drain: got %h expected 1, model count %h",
               $sampled(empty), $sampled(model_count));
      errors++;
    end

  task automatic fill_until_full(int extra);
    @(negedge wr_clk);
    fill_phase = 1'b1;
    wr_en      = 1'b1;
    wr_data    = rand_word();
    while (!full) begin
      @(negedge wr_clk);
      wr_data = rand_word();
    end
    repeat (extra) begin
      @(negedge wr_clk);
      wr_data = rand_word(); // Ignored while full.
    end
    wr_en      = 1'b0;
    fill_phase = 1'b0;
  endtask

  task automatic drain_until_empty(int extra);
    repeat (6) @(negedge rd_clk); // Let the write pointer settle across.
    drain_phase = 1'b1;
    rd_en       = 1'b1;
    while (!empty) @(negedge rd_clk);
    repeat (extra) @(negedge rd_clk);
    rd_en       = 1'b0;
    drain_phase = 1'b0;
    drained     = 1'b1;
    repeat (2) @(negedge rd_clk);
    drained     = 1'b0;
  endtask

  task automatic write_random(int cycles, int quarters);
    repeat (cycles) begin
      @(negedge wr_clk);
      wr_en   = chance(quarters, 1'b0);
      wr_data = rand_word();
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  task automatic read_random(int cycles, int quarters);
    repeat (cycles) begin
      @(negedge rd_clk);
      rd_en = chance(quarters, 1'b1);
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
  endtask

  task automatic run_random(int wr_quarters, int rd_quarters);
    fork
      write_random(RAND_WR_CYCLES, wr_quarters);
      read_random(RAND_RD_CYCLES, rd_quarters);
    join
  endtask

  task automatic report_test(string name);
    repeat (2) @(negedge rd_clk); // Late assertion hits still count here.
    if (errors == errors_at_start) begin
      passed++;
      $display("test %-20s pass", name);
    end else begin
      failed++;
      $display("test %-20s fail, %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge rd_clk);
      cycles++;
    end
    $display("Timeout after %0d rd_clk cycles, a test never finished.", cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    repeat (8) @(negedge rd_clk);
    rd_rst_n = 1'b1;
    @(negedge wr_clk);
    wr_rst_n = 1'b1;
    repeat (4) @(negedge rd_clk);
    report_test("reset_flags");

    fill_until_full(EXTRA_REQS);
    report_test("fill_to_full");
    drain_until_empty(EXTRA_REQS);
    report_test("drain_to_empty");

    run_random(3, 1);
    report_test("random_write_heavy");
    run_random(2, 2);
    report_test("random_balanced");
    run_random(1, 3);
    report_test("random_read_heavy");
    drain_until_empty(EXTRA_REQS);
    report_test("final_drain");

    $display("tests passed %0d, failed %0d, check errors %0d", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+verilog
verilog/afifo_pkg.sv
verilog/afifo_ram_if.sv
verilog/afifo_ram.sv
verilog/afifo_ptr_sync.sv
verilog/afifo_wr_ctrl.sv
verilog/afifo_rd_ctrl.sv
verilog/async_fifo.sv
bench/async_fifo_tb.sv

//--- Bender.yml
package:
  name: async_fifo

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/afifo_pkg.sv
      - verilog/afifo_ram_if.sv
      - verilog/afifo_ram.sv
      - verilog/afifo_ptr_sync.sv
      - verilog/afifo_wr_ctrl.sv
      - verilog/afifo_rd_ctrl.sv
      - verilog/async_fifo.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/async_fifo_tb.sv
